// ==== tag_sched.f ====
+incdir+rtl
rtl/sched_pkg.sv
rtl/rs_bank.sv
rtl/issue_select.sv
rtl/alu_unit.sv
rtl/cdb_arbiter.sv
rtl/tag_sched.sv
tests/tag_sched_tb.sv

// ==== tests/tag_sched_tb.sv ====
// Testbench for tag_sched with a stimulus table, reference model, credit tracking and timeout

`timescale 1ns/1ps

`include "sched_defs.svh"

module tag_sched_tb;

    import sched_pkg::*;

    logic         clock = 1'b0;
    logic         reset;
    disp_packet_t dispatch;
    logic [1:0]   dispatch_credit;
    cdb_packet_t  result;

    // Stimulus table, one row per instruction, row index is the dest tag
    string         row_name[$];
    alu_op_t       row_op[$];
    bit            row_ta[$];
    bit            row_tb[$];
    logic [31:0]   row_a[$];
    logic [31:0]   row_b[$];
    logic [31:0]   exp_val[$];
    // One past the last row of each test
    int            test_end[$];

    // Dispatcher and scoreboard state
    bit            done[64];
    int            next_row = 0;
    int            completed = 0;
    int            credits = `SCHED_RS_SIZE;
    int            returned = 0;
    int            stalls = 0;
    int            cycle_count = 0;
    int            cycle_limit = 100;
    logic [31:0]   lfsr_q = 32'h867cf57c;

    tag_sched i_dut (
        .clock          (clock),
        .reset          (reset),
        .dispatch       (dispatch),
        .dispatch_credit(dispatch_credit),
        .result         (result)
    );

    always #5 clock = ~clock;

    //////////////////////////////////////////////////////////////////////
    // Reporting and checks
    //////////////////////////////////////////////////////////////////////

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first failure");
    endtask

    // Ends the run once the table has had ample time to drain
    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            fail_run($sformatf("timeout after %0d cycles with %0d of %0d results seen",
                cycle_count, completed, next_row));
        end
    end

    // Broadcast against the reference value of its tag
    task automatic check_result(input cdb_packet_t got, input int issued);
        int idx;
        idx = int'(got.tag);
        if (idx >= issued) begin
            fail_run($sformatf("result carries tag %0d, which was never dispatched", idx));
        end else if (done[idx]) begin
            fail_run($sformatf("result for tag %0d appeared a second time", idx));
        end else if (got.value !== exp_val[idx]) begin
            fail_run($sformatf("error %s: tag %0d expected %h actual %h",
                row_name[idx], idx, exp_val[idx], got.value));
        end
        done[idx] = 1'b1;
        completed++;
    endtask

    task automatic check_credit(input string name, input int expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("error %s: expected %0d actual %0d", name, expected, actual));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Random numbers and reference model
    //////////////////////////////////////////////////////////////////////

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            w      = {w[30:0], lfsr_q[0]};
        end
        return w;
    endfunction

    // Op rules, shift amount is the low 5 bits of b
    function automatic logic [31:0] ref_alu(input alu_op_t op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_sll:  return a << b[4:0];
            default: return '0;
        endcase
    endfunction

    // Expected value is resolved in table order
    task automatic add_row(input string name, input alu_op_t op, input bit ta,
                           input logic [31:0] a, input bit tb, input logic [31:0] b);
        logic [31:0] va;
        logic [31:0] vb;
        va = ta ? exp_val[a] : a;
        vb = tb ? exp_val[b] : b;
        row_name.push_back(name);
        row_op.push_back(op);
        row_ta.push_back(ta);
        row_tb.push_back(tb);
        row_a.push_back(a);
        row_b.push_back(b);
        exp_val.push_back(ref_alu(op, va, vb));
    endtask

    task automatic build_table();
        int          base;
        logic [31:0] ra;
        logic [31:0] rb;
        alu_op_t     rop;
        // Every op on immediates, second shift uses only b[4:0]
        add_row("independent", op_add, 0, 32'd5, 0, 32'd7);
        add_row("independent", op_sub, 0, 32'd3, 0, 32'd10);
        add_row("independent", op_and, 0, 32'hf0f0_ff00, 0, 32'h0ff0_f0f0);
        add_row("independent", op_or, 0, 32'h1200_0034, 0, 32'h0056_7800);
        add_row("independent", op_xor, 0, 32'hdead_beef, 0, 32'hffff_0000);
        add_row("independent", op_sll, 0, 32'd1, 0, 32'd31);
        add_row("independent", op_sll, 0, 32'h0000_00ff, 0, 32'hffff_ffe5);
        test_end.push_back(row_op.size());
        // Row 3 lands in the cycle of row 0's broadcast
        base = row_op.size();
        add_row("forward", op_add, 0, 32'd100, 0, 32'd23);
        add_row("forward", op_xor, 0, 32'h55, 0, 32'haa);
        add_row("forward", op_or, 0, 32'd1, 0, 32'd2);
        add_row("forward", op_sub, 1, base, 1, base + 1);
        add_row("forward", op_sll, 1, base + 3, 0, 32'd4);
        test_end.push_back(row_op.size());
        // Long chain fills the bank behind its root
        base = row_op.size();
        add_row("chain", op_add, 0, 32'd1, 0, 32'd1);
        for (int k = 1; k < 16; k++) begin
            add_row("chain", alu_op_t'(k % 6), 1, base + k - 1, 0, k + 3);
        end
        test_end.push_back(row_op.size());
        // Back to back random ops fight for the bus
        for (int k = 0; k < 20; k++) begin
            rop = alu_op_t'(3'(random_bits(3) % 6));
            ra  = random_bits(32);
            rb  = random_bits(32);
            add_row("contention", rop, 0, ra, 0, rb);
        end
        test_end.push_back(row_op.size());
    endtask

    //////////////////////////////////////////////////////////////////////
    // Dispatcher
    //////////////////////////////////////////////////////////////////////

    // Value once the producer has broadcast, else the producer tag
    function automatic src_t make_src(input bit is_tag, input logic [31:0] v);
        src_t s;
        s = '0;
        if (is_tag && !done[v]) begin
            s.opnd.tag_view.tag = v[`SCHED_TAG_W-1:0];
        end else begin
            s.ready      = 1'b1;
            s.opnd.value = is_tag ? exp_val[v] : v;
        end
        return s;
    endfunction

    // One cycle, called just after the rising edge
    task automatic run_cycle(input int last);
        int issued;
        issued   = next_row;
        credits  = credits + dispatch_credit;
        returned = returned + dispatch_credit;
        if (credits > `SCHED_RS_SIZE) begin
            fail_run("dispatcher holds more credits than the bank has entries");
        end
        dispatch = '0;
        if (credits > 0 && next_row < last) begin
            dispatch.valid    = 1'b1;
            dispatch.dest_tag = next_row[`SCHED_TAG_W-1:0];
            dispatch.op       = row_op[next_row];
            dispatch.src_a    = make_src(row_ta[next_row], row_a[next_row]);
            dispatch.src_b    = make_src(row_tb[next_row], row_b[next_row]);
            credits--;
            next_row++;
        end else if (next_row < last) begin
            stalls++;
        end
        // Recorded after the dispatch so a same-cycle broadcast goes in as a tag
        if (result.valid) begin
            check_result(result, issued);
        end
    endtask

    initial begin
        reset    = 1'b1;
        dispatch = '0;
        build_table();
        cycle_limit = 20 * row_op.size() + 100;
        repeat (5) begin
            @(posedge clock);
            #1;
            if (result.valid !== 1'b0) begin
                fail_run("result valid while reset is held");
            end
            check_credit("reset credit", 0, dispatch_credit);
        end
        reset = 1'b0;
        @(posedge clock);
        #1;
        if (result.valid !== 1'b0) begin
            fail_run("result valid in the first cycle after reset");
        end
        check_credit("post reset credit", 0, dispatch_credit);
        // Each test drains before the next one starts
        for (int t = 0; t < test_end.size(); t++) begin
            while (next_row < test_end[t] || completed < next_row) begin
                @(posedge clock);
                #1;
                run_cycle(test_end[t]);
            end
        end
        // A repeated broadcast of the last tag would follow right behind it
        repeat (4) begin
            @(posedge clock);
            #1;
            run_cycle(next_row);
        end
        check_credit("credit total", next_row, returned);
        if (stalls == 0) begin
            fail_run("dispatch never waited on a full bank");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

// ==== rtl/tag_sched.sv ====
// Scheduler top level joining the bank, selector, ALU units and result bus

`timescale 1ns/1ps

`include "sched_defs.svh"

module tag_sched (
    input  logic                    clock,
    input  logic                    reset,
    // Renamed instruction, valid only while a credit is held
    input  sched_pkg::disp_packet_t dispatch,
    // Freed entries returned to the dispatcher
    output logic [1:0]              dispatch_credit,
    // Result bus broadcast
    output sched_pkg::cdb_packet_t  result
);

    import sched_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Internal wires
    //////////////////////////////////////////////////////////////////////

    // Bank to selector
    rs_entry_t     [`SCHED_RS_SIZE-1:0] entries;
    logic          [`SCHED_RS_SIZE-1:0] clear_mask;

    // Selector to units
    issue_packet_t [`SCHED_NUM_ALU-1:0] issue;
    logic          [`SCHED_NUM_ALU-1:0] alu_free;

    // Units to arbiter
    cdb_packet_t   [`SCHED_NUM_ALU-1:0] request;
    logic          [`SCHED_NUM_ALU-1:0] grant;

    //////////////////////////////////////////////////////////////////////
    // Reservation station and issue
    //////////////////////////////////////////////////////////////////////

    // Wakes from the same broadcast that leaves as the result
    rs_bank i_rs_bank (
        .clock          (clock),
        .reset          (reset),
        .dispatch       (dispatch),
        .broadcast      (result),
        .clear_mask     (clear_mask),
        .entries        (entries),
        .dispatch_credit(dispatch_credit)
    );

    issue_select i_issue_select (
        .entries   (entries),
        .alu_free  (alu_free),
        .issue     (issue),
        .clear_mask(clear_mask)
    );

    //////////////////////////////////////////////////////////////////////
    // Execution and result bus
    //////////////////////////////////////////////////////////////////////

    for (genvar u = 0; u < `SCHED_NUM_ALU; u++) begin : g_alu
        alu_unit i_alu_unit (
            .clock  (clock),
            .reset  (reset),
            .grant  (grant[u]),
            .issue  (issue[u]),
            .request(request[u]),
            .free   (alu_free[u])
        );
    end

    cdb_arbiter i_cdb_arbiter (
        .clock    (clock),
        .reset    (reset),
        .request  (request),
        .grant    (grant),
        .broadcast(result)
    );

endmodule

// ==== rtl/cdb_arbiter.sv ====
// Round-robin result bus arbiter with a registered broadcast

`timescale 1ns/1ps

`include "sched_defs.svh"

module cdb_arbiter (
    input  logic                                        clock,
    input  logic                                        reset,
    // One request per ALU unit
    input  sched_pkg::cdb_packet_t [`SCHED_NUM_ALU-1:0] request,
    output logic [`SCHED_NUM_ALU-1:0]                   grant,
    // Winner of the previous cycle
    output sched_pkg::cdb_packet_t                      broadcast
);

    import sched_pkg::*;

    localparam int num_req = `SCHED_NUM_ALU;
    localparam int ptr_w   = (num_req > 1) ? $clog2(num_req) : 1;

    // Highest-priority requester this cycle
    logic [ptr_w-1:0] rr_ptr;
    logic [ptr_w-1:0] win_idx;
    logic             win_found;

    //////////////////////////////////////////////////////////////////////
    // Grant
    //////////////////////////////////////////////////////////////////////

    // Search starts at the pointer and wraps
    always_comb begin
        grant     = '0;
        win_idx   = '0;
        win_found = 1'b0;
        for (int k = 0; k < num_req; k++) begin
            if (!win_found && request[(int'(rr_ptr) + k) % num_req].valid) begin
                win_found = 1'b1;
                win_idx   = ptr_w'((int'(rr_ptr) + k) % num_req);
            end
        end
        if (win_found) begin
            grant[win_idx] = 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pointer and broadcast register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            rr_ptr          <= '0;
            broadcast.valid <= 1'b0;
        end else begin
            // Move one past the last winner
            if (win_found) begin
                rr_ptr <= (int'(win_idx) == num_req - 1) ? '0 : win_idx + 1'b1;
            end
            broadcast.valid <= win_found;
        end
    end

    // Tag and value of the winning request
    always_ff @(posedge clock) begin
        broadcast.tag   <= request[win_idx].tag;
        broadcast.value <= request[win_idx].value;
    end

endmodule

// ==== rtl/alu_unit.sv ====
// Single-cycle ALU unit holding its result until the result bus grants it

`timescale 1ns/1ps

`include "sched_defs.svh"

module alu_unit (
    input  logic                      clock,
    input  logic                      reset,
    // Bus grant for the current request
    input  logic                      grant,
    input  sched_pkg::issue_packet_t  issue,
    output sched_pkg::cdb_packet_t    request,
    // Ready to take a new issue
    output logic                      free
);

    import sched_pkg::*;

    issue_packet_t            held_q;
    logic                     hold_q;
    logic [`SCHED_DATA_W-1:0] alu_result;

    //////////////////////////////////////////////////////////////////////
    // Hold state
    //////////////////////////////////////////////////////////////////////

    // Set on issue, dropped at the grant edge
    always_ff @(posedge clock) begin
        if (reset) begin
            hold_q <= 1'b0;
        end else if (issue.valid) begin
            hold_q <= 1'b1;
        end else if (grant) begin
            hold_q <= 1'b0;
        end
    end

    // Operand capture
    always_ff @(posedge clock) begin
        if (issue.valid) begin
            held_q <= issue;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (held_q.op)
            op_add:  alu_result = held_q.opa + held_q.opb;
            op_sub:  alu_result = held_q.opa - held_q.opb;
            op_and:  alu_result = held_q.opa & held_q.opb;
            op_or:   alu_result = held_q.opa | held_q.opb;
            op_xor:  alu_result = held_q.opa ^ held_q.opb;
            op_sll:  alu_result = held_q.opa << held_q.opb[4:0];
            default: alu_result = '0;
        endcase
    end

    // Request stays up, unchanged, until granted
    assign request.valid = hold_q;
    assign request.tag   = held_q.dest_tag;
    assign request.value = alu_result;

    assign free = ~hold_q;

endmodule

// ==== rtl/issue_select.sv ====
// Issue selector steering up to two ready entries to the free ALU units

`timescale 1ns/1ps

`include "sched_defs.svh"

module issue_select (
    // Current bank contents
    input  sched_pkg::rs_entry_t [`SCHED_RS_SIZE-1:0]     entries,
    // Unit is not holding a result
    input  logic [`SCHED_NUM_ALU-1:0]                     alu_free,
    output sched_pkg::issue_packet_t [`SCHED_NUM_ALU-1:0] issue,
    // Entries issued this cycle, cleared at the next edge
    output logic [`SCHED_RS_SIZE-1:0]                     clear_mask
);

    import sched_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Ready detection
    //////////////////////////////////////////////////////////////////////

    logic [`SCHED_RS_SIZE-1:0] ready;

    // Busy with both sources holding values
    always_comb begin
        for (int e = 0; e < `SCHED_RS_SIZE; e++) begin
            ready[e] = entries[e].busy && entries[e].src_a.ready && entries[e].src_b.ready;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Selection
    //////////////////////////////////////////////////////////////////////

    // Ready entries not yet given to a unit
    logic [`SCHED_RS_SIZE-1:0] avail;
    // Current unit already has an entry
    logic                      picked;

    // Lower units take lower indices first
    always_comb begin
        avail      = ready;
        clear_mask = '0;
        issue      = '0;
        picked     = 1'b0;
        for (int u = 0; u < `SCHED_NUM_ALU; u++) begin
            picked = 1'b0;
            for (int e = 0; e < `SCHED_RS_SIZE; e++) begin
                if (alu_free[u] && !picked && avail[e]) begin
                    picked              = 1'b1;
                    avail[e]            = 1'b0;
                    clear_mask[e]       = 1'b1;
                    issue[u].valid      = 1'b1;
                    issue[u].dest_tag   = entries[e].dest_tag;
                    issue[u].op         = entries[e].op;
                    // Both sources are ready, so the union holds values
                    issue[u].opa        = entries[e].src_a.opnd.value;
                    issue[u].opb        = entries[e].src_b.opnd.value;
                end
            end
        end
    end

endmodule

// ==== rtl/rs_bank.sv ====
// Reservation-station bank with allocation, tag wakeup, issue clear and credit return

`timescale 1ns/1ps

`include "sched_defs.svh"

module rs_bank (
    input  logic                                          clock,
    input  logic                                          reset,
    // Renamed instruction, always accepted
    input  sched_pkg::disp_packet_t                       dispatch,
    // Registered result bus, wakeup source
    input  sched_pkg::cdb_packet_t                        broadcast,
    // Entries picked by the selector this cycle
    input  logic [`SCHED_RS_SIZE-1:0]                     clear_mask,
    output sched_pkg::rs_entry_t [`SCHED_RS_SIZE-1:0]     entries,
    // Number of entries freed at the last edge, 0 to 2
    output logic [1:0]                                    dispatch_credit
);

    import sched_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Entry storage
    //////////////////////////////////////////////////////////////////////

    rs_entry_t [`SCHED_RS_SIZE-1:0] rs_q;

    // Lowest free slot for the incoming packet
    logic [`SCHED_IDX_W-1:0] alloc_idx;
    logic                    alloc_hit;
    logic                    alloc_en;

    // Entries leaving on this edge
    logic [1:0] clear_count;

    // Capture the broadcast value when a pending source matches its tag
    function automatic src_t wake_src(input src_t src, input cdb_packet_t bc);
        src_t woken;
        woken = src;
        if (!src.ready && bc.valid && (src.opnd.tag_view.tag == bc.tag)) begin
            woken.ready      = 1'b1;
            woken.opnd.value = bc.value;
        end
        return woken;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Allocation
    //////////////////////////////////////////////////////////////////////

    // Scan downward so the last hit is the lowest free index
    always_comb begin
        alloc_idx = '0;
        alloc_hit = 1'b0;
        for (int i = `SCHED_RS_SIZE - 1; i >= 0; i--) begin
            if (!rs_q[i].busy) begin
                alloc_idx = i[`SCHED_IDX_W-1:0];
                alloc_hit = 1'b1;
            end
        end
    end

    // Credits guarantee a free slot whenever valid is high
    assign alloc_en = dispatch.valid && alloc_hit;

    //////////////////////////////////////////////////////////////////////
    // Clear count for the credit return
    //////////////////////////////////////////////////////////////////////

    // At most one entry per ALU unit is cleared per cycle
    always_comb begin
        clear_count = 2'd0;
        for (int i = 0; i < `SCHED_RS_SIZE; i++) begin
            if (clear_mask[i] && rs_q[i].busy) begin
                clear_count = clear_count + 2'd1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Entry update
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            // Empty bank, no credit pulse
            for (int i = 0; i < `SCHED_RS_SIZE; i++) begin
                rs_q[i].busy <= 1'b0;
            end
            dispatch_credit <= 2'd0;
        end else begin
            for (int i = 0; i < `SCHED_RS_SIZE; i++) begin
                if (clear_mask[i]) begin
                    // Issued, slot returns to the free pool
                    rs_q[i].busy <= 1'b0;
                end else if (alloc_en && (alloc_idx == i[`SCHED_IDX_W-1:0])) begin
                    // New entry, same-cycle broadcast is applied on the way in
                    rs_q[i].busy     <= 1'b1;
                    rs_q[i].dest_tag <= dispatch.dest_tag;
                    rs_q[i].op       <= dispatch.op;
                    rs_q[i].src_a    <= wake_src(dispatch.src_a, broadcast);
                    rs_q[i].src_b    <= wake_src(dispatch.src_b, broadcast);
                end else begin
                    // Resident entry, snoop the bus
                    rs_q[i].src_a <= wake_src(rs_q[i].src_a, broadcast);
                    rs_q[i].src_b <= wake_src(rs_q[i].src_b, broadcast);
                end
            end
            // One-cycle pulse of the freed count
            dispatch_credit <= clear_count;
        end
    end

    assign entries = rs_q;

endmodule

// ==== rtl/sched_pkg.sv ====
// Scheduler package with the ALU op enum, operand union and packet structs

`include "sched_defs.svh"

package sched_pkg;

    // ALU operations, shift amount is opb[4:0]
    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        op_sll = 3'd5
    } alu_op_t;

    // Tag view of an operand word, tag sits in the low bits
    typedef struct packed {
        logic [`SCHED_DATA_W-`SCHED_TAG_W-1:0] pad;
        logic [`SCHED_TAG_W-1:0]               tag;
    } tag_view_t;

    // One operand word, decoded as a value or as a producer tag
    typedef union packed {
        logic [`SCHED_DATA_W-1:0] value;
        tag_view_t                tag_view;
    } operand_u;

    // Source operand, ready means the union holds a value
    typedef struct packed {
        logic     ready;
        operand_u opnd;
    } src_t;

    // Renamed instruction from the dispatcher
    typedef struct packed {
        logic                    valid;
        logic [`SCHED_TAG_W-1:0] dest_tag;
        alu_op_t                 op;
        src_t                    src_a;
        src_t                    src_b;
    } disp_packet_t;

    // Stored reservation-station entry
    typedef struct packed {
        logic                    busy;
        logic [`SCHED_TAG_W-1:0] dest_tag;
        alu_op_t                 op;
        src_t                    src_a;
        src_t                    src_b;
    } rs_entry_t;

    // Issued instruction, operands resolved to values
    typedef struct packed {
        logic                     valid;
        logic [`SCHED_TAG_W-1:0]  dest_tag;
        alu_op_t                  op;
        logic [`SCHED_DATA_W-1:0] opa;
        logic [`SCHED_DATA_W-1:0] opb;
    } issue_packet_t;

    // Result bus request and broadcast
    typedef struct packed {
        logic                     valid;
        logic [`SCHED_TAG_W-1:0]  tag;
        logic [`SCHED_DATA_W-1:0] value;
    } cdb_packet_t;

endpackage

// ==== rtl/sched_defs.svh ====
// Width and size macros shared by the tag scheduler RTL

`ifndef SCHED_DEFS_SVH
`define SCHED_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// Reservation station
//////////////////////////////////////////////////////////////////////

// Entries in the single bank
`define SCHED_RS_SIZE 8
// Entry index width, log2 of the bank size
`define SCHED_IDX_W 3

//////////////////////////////////////////////////////////////////////
// Execution and result bus
//////////////////////////////////////////////////////////////////////

// Single-cycle ALU units behind the result bus
`define SCHED_NUM_ALU 2
// Physical register tag
`define SCHED_TAG_W 6
// Data word carried by operands and results
`define SCHED_DATA_W 32

`endif
